//--- src/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Width of the registers, the datapath and the program counter.
`define XLEN 64

// Number of integer registers, x0 included.
`define REG_COUNT 32

// Data memory size in doublewords.
`define MEM_DEPTH 32

`endif

//--- src/corePkg.sv
package corePkg;

    // Major opcodes of the supported RV64I instructions.
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS_B} aluOp_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} immType_t;

    typedef enum logic [1:0] {ST_IDLE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK} coreState_t;

    // Writeback mux selections.
    localparam logic [1:0] WB_ALU    = 2'd0;
    localparam logic [1:0] WB_MEMORY = 2'd1;
    localparam logic [1:0] WB_LINK   = 2'd2; // Return address of JAL and JALR.

    // Next PC selections.
    localparam logic [1:0] PC_NEXT   = 2'd0;
    localparam logic [1:0] PC_TARGET = 2'd1; // Taken branch or JAL.
    localparam logic [1:0] PC_JUMP   = 2'd2; // JALR.

endpackage

//--- src/immediateGenerator.sv
`timescale 1ns/1ps
`include "core_config.svh"

module immediateGenerator (
    input  logic [31:0]        instruction,
    input  corePkg::immType_t  immType,
    output logic [`XLEN-1:0]   immediate
);
    import corePkg::*;

    logic        signBit;
    logic [11:0] iField;
    logic [11:0] sField;
    logic [12:0] bField;
    logic [20:0] jField;
    logic [31:0] uField;

    assign signBit = instruction[31]; // Every format keeps its sign in bit 31.

    // Loads, ADDI and JALR.
    assign iField = instruction[31:20];

    // Stores split the offset around rd.
    assign sField = {instruction[31:25], instruction[11:7]};

    // Branch offsets are in halfwords, so bit 0 is always zero.
    assign bField = {instruction[31], instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};

    assign jField = {instruction[31], instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};

    assign uField = {instruction[31:12], 12'b0}; // Upper 20 bits, low 12 cleared.

    always_comb begin
        case (immType)
            IMM_I:   immediate = {{(`XLEN - 12){signBit}}, iField};
            IMM_S:   immediate = {{(`XLEN - 12){signBit}}, sField};
            IMM_B:   immediate = {{(`XLEN - 13){signBit}}, bField};
            IMM_J:   immediate = {{(`XLEN - 21){signBit}}, jField};
            IMM_U:   immediate = {{(`XLEN - 32){signBit}}, uField};
            default: immediate = '0;
        endcase
    end

endmodule

//--- src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic               clock,
    input  logic               reset,
    input  logic [31:0]        instruction,
    input  logic               instructionValid,
    input  logic               equal,
    output logic               ready,
    output logic               retire,
    output logic [31:0]        latchedInstruction,
    output corePkg::immType_t  immType,
    output corePkg::aluOp_t    aluOp,
    output logic               useImmediate,
    output logic               memWrite,
    output logic               regWrite,
    output logic [1:0]         writeSelect,
    output logic               pcWrite,
    output logic [1:0]         pcSelect
);
    import corePkg::*;

    coreState_t state;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic       writesRd;
    logic       needsMemory; // Loads and stores pass through ST_MEMORY.
    logic       branchTaken;

    assign opcode = opcode_t'(latchedInstruction[6:0]);
    assign funct3 = latchedInstruction[14:12];
    assign rd = latchedInstruction[11:7];

    // Only BEQ and BNE exist; other branch encodings fall through to PC + 4.
    always_comb begin
        case (funct3)
            3'b000:  branchTaken = equal;
            3'b001:  branchTaken = !equal;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        immType = IMM_I;
        aluOp = ALU_ADD;
        useImmediate = 1'b0;
        writesRd = 1'b0;
        needsMemory = 1'b0;
        writeSelect = WB_ALU;
        pcSelect = PC_NEXT;
        case (opcode)
            OP_REG: begin
                writesRd = 1'b1;
                aluOp = latchedInstruction[30] ? ALU_SUB : ALU_ADD; // funct7 bit 5.
            end
            OP_IMM: begin
                useImmediate = 1'b1;
                writesRd = 1'b1;
            end
            OP_LOAD: begin
                useImmediate = 1'b1;
                writesRd = 1'b1;
                needsMemory = 1'b1;
                writeSelect = WB_MEMORY;
            end
            OP_STORE: begin
                immType = IMM_S;
                useImmediate = 1'b1;
                needsMemory = 1'b1;
            end
            OP_BRANCH: begin
                immType = IMM_B;
                pcSelect = branchTaken ? PC_TARGET : PC_NEXT;
            end
            OP_JAL: begin
                immType = IMM_J;
                writesRd = 1'b1;
                writeSelect = WB_LINK;
                pcSelect = PC_TARGET;
            end
            OP_JALR: begin
                useImmediate = 1'b1;
                writesRd = 1'b1;
                writeSelect = WB_LINK;
                pcSelect = PC_JUMP;
            end
            OP_LUI: begin
                immType = IMM_U;
                useImmediate = 1'b1;
                aluOp = ALU_PASS_B;
                writesRd = 1'b1;
            end
            default: ; // Unknown opcodes retire as a no-op.
        endcase
    end

    // Ready stays low through the retire cycle.
    assign ready = (state == ST_IDLE) && !retire;
    assign memWrite = (state == ST_MEMORY) && (opcode == OP_STORE);
    assign regWrite = (state == ST_WRITEBACK) && writesRd && (rd != 5'd0);
    assign pcWrite = (state == ST_WRITEBACK);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
            retire <= 1'b0;
        end else begin
            retire <= (state == ST_WRITEBACK);
            case (state)
                ST_IDLE:    if (instructionValid && ready) state <= ST_EXECUTE;
                ST_EXECUTE: state <= needsMemory ? ST_MEMORY : ST_WRITEBACK;
                ST_MEMORY:  state <= ST_WRITEBACK;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (instructionValid && ready) latchedInstruction <= instruction;
    end

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ps
`include "core_config.svh"

module registerFile (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [$clog2(`REG_COUNT)-1:0] readAddressA,
    input  logic [$clog2(`REG_COUNT)-1:0] readAddressB,
    input  logic                          writeEnable,
    input  logic [$clog2(`REG_COUNT)-1:0] writeAddress,
    input  logic [`XLEN-1:0]              writeData,
    output logic [`XLEN-1:0]              readDataA,
    output logic [`XLEN-1:0]              readDataB
);

    logic [`XLEN-1:0] registers [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && (writeAddress != '0)) begin
            registers[writeAddress] <= writeData; // x0 is never written.
        end
    end

    assign readDataA = (readAddressA == '0) ? '0 : registers[readAddressA];
    assign readDataB = (readAddressB == '0) ? '0 : registers[readAddressB];

endmodule

//--- src/arithmeticUnit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module arithmeticUnit (
    input  logic [`XLEN-1:0] operandA,
    input  logic [`XLEN-1:0] operandB,
    input  logic [`XLEN-1:0] immediate,
    input  logic             useImmediate,
    input  corePkg::aluOp_t  aluOp,
    input  logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] result,
    output logic             equal,
    output logic [`XLEN-1:0] pcPlusFour,
    output logic [`XLEN-1:0] pcTarget,
    output logic [`XLEN-1:0] jumpTarget
);
    import corePkg::*;

    logic [`XLEN-1:0] secondOperand;
    logic [`XLEN-1:0] jumpSum;

    assign secondOperand = useImmediate ? immediate : operandB;

    always_comb begin
        case (aluOp)
            ALU_ADD:    result = operandA + secondOperand;
            ALU_SUB:    result = operandA - secondOperand;
            ALU_PASS_B: result = secondOperand; // LUI.
            default:    result = '0;
        endcase
    end

    // Branches always compare the two registers.
    assign equal = (operandA == operandB);

    assign pcPlusFour = pc + `XLEN'(4);
    assign pcTarget = pc + immediate;
    assign jumpSum = operandA + immediate;
    assign jumpTarget = {jumpSum[`XLEN-1:1], 1'b0}; // JALR clears bit 0.

endmodule

//--- src/dataMemory.sv
`timescale 1ns/1ps
`include "core_config.svh"

module dataMemory (
    input  logic             clock,
    input  logic             reset,
    input  logic [`XLEN-1:0] address,
    input  logic             writeEnable,
    input  logic [`XLEN-1:0] writeData,
    output logic [`XLEN-1:0] readData
);

    localparam int indexWidth = $clog2(`MEM_DEPTH);

    logic [`XLEN-1:0]      storage [`MEM_DEPTH];
    logic [indexWidth-1:0] index;

    assign index = address[3 +: indexWidth]; // Doubleword index, wraps at the depth.

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                storage[i] <= '0;
            end
        end else if (writeEnable) begin
            storage[index] <= writeData;
        end
    end

    assign readData = storage[index];

endmodule

//--- src/rvCore.sv
`timescale 1ns/1ps
`include "core_config.svh"

module rvCore (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [31:0]                   instruction,
    input  logic                          instructionValid,
    output logic                          ready,
    output logic                          retire,
    output logic                          writeEnable,
    output logic [$clog2(`REG_COUNT)-1:0] writeAddress,
    output logic [`XLEN-1:0]              writeData,
    output logic [`XLEN-1:0]              pc
);
    import corePkg::*;

    logic [31:0]      latchedInstruction;
    immType_t         immType;
    aluOp_t           aluOp;
    logic             useImmediate;
    logic             memWrite;
    logic             regWrite;
    logic [1:0]       writeSelect;
    logic             pcWrite;
    logic [1:0]       pcSelect;
    logic             equal;
    logic [`XLEN-1:0] immediate;
    logic [`XLEN-1:0] readDataA;
    logic [`XLEN-1:0] readDataB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] pcPlusFour;
    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] jumpTarget;
    logic [`XLEN-1:0] memReadData;
    logic [`XLEN-1:0] writeBackData;
    logic [`XLEN-1:0] nextPc;

    controlUnit controlUnit_i (
        .clock(clock), .reset(reset), .instruction(instruction),
        .instructionValid(instructionValid), .equal(equal), .ready(ready),
        .retire(retire), .latchedInstruction(latchedInstruction), .immType(immType),
        .aluOp(aluOp), .useImmediate(useImmediate), .memWrite(memWrite),
        .regWrite(regWrite), .writeSelect(writeSelect), .pcWrite(pcWrite),
        .pcSelect(pcSelect)
    );

    immediateGenerator immediateGenerator_i (
        .instruction(latchedInstruction), .immType(immType), .immediate(immediate)
    );

    registerFile registerFile_i (
        .clock(clock), .reset(reset),
        .readAddressA(latchedInstruction[19:15]), .readAddressB(latchedInstruction[24:20]),
        .writeEnable(regWrite), .writeAddress(latchedInstruction[11:7]),
        .writeData(writeBackData), .readDataA(readDataA), .readDataB(readDataB)
    );

    arithmeticUnit arithmeticUnit_i (
        .operandA(readDataA), .operandB(readDataB), .immediate(immediate),
        .useImmediate(useImmediate), .aluOp(aluOp), .pc(pc), .result(aluResult),
        .equal(equal), .pcPlusFour(pcPlusFour), .pcTarget(pcTarget),
        .jumpTarget(jumpTarget)
    );

    dataMemory dataMemory_i (
        .clock(clock), .reset(reset), .address(aluResult), .writeEnable(memWrite),
        .writeData(readDataB), .readData(memReadData)
    );

    always_comb begin
        case (writeSelect)
            WB_MEMORY: writeBackData = memReadData;
            WB_LINK:   writeBackData = pcPlusFour;
            default:   writeBackData = aluResult;
        endcase
    end

    always_comb begin
        case (pcSelect)
            PC_TARGET: nextPc = pcTarget;
            PC_JUMP:   nextPc = jumpTarget;
            default:   nextPc = pcPlusFour;
        endcase
    end

    // The writeback ports are registered so they line up with retire.
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            writeEnable <= 1'b0;
        end else begin
            writeEnable <= regWrite;
            if (pcWrite) pc <= nextPc;
        end
    end

    always_ff @(posedge clock) begin
        if (pcWrite) begin
            writeAddress <= latchedInstruction[11:7];
            writeData <= writeBackData;
        end
    end

endmodule

//--- testbench/clockGenerator.sv
`timescale 1ns/1ps

module clockGenerator #(
    parameter int period = 40 // Clock period in ns.
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

endmodule

//--- testbench/rvCoreTb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module rvCoreTb;
    import corePkg::*;

    localparam int clockPeriod = 40;
    localparam int resetCycles = 10;
    localparam int programLength = 400;
    localparam int setupLength = 16; // Leading ADDI and LUI instructions.
    localparam int memIndexWidth = $clog2(`MEM_DEPTH);

    typedef enum {KIND_ADD, KIND_SUB, KIND_ADDI, KIND_LUI, KIND_LD, KIND_SD, KIND_BEQ,
                  KIND_BNE, KIND_JAL, KIND_JALR, KIND_ILLEGAL} instrKind_t;

    logic             clock;
    logic             reset;
    logic [31:0]      instruction;
    logic             instructionValid;
    logic             ready;
    logic             retire;
    logic             writeEnable;
    logic [4:0]       writeAddress;
    logic [`XLEN-1:0] writeData;
    logic [`XLEN-1:0] pc;

    // Architectural state of the reference model.
    logic [`XLEN-1:0] modelRegs [`REG_COUNT];
    logic [`XLEN-1:0] modelMem [`MEM_DEPTH];
    logic [`XLEN-1:0] modelPc;
    logic             haveStore;
    logic [4:0]       lastStoreBase;
    logic [11:0]      lastStoreOffset;

    clockGenerator #(.period(clockPeriod)) clockGenerator_i (.clock(clock));

    rvCore rvCore_i (
        .clock(clock), .reset(reset), .instruction(instruction),
        .instructionValid(instructionValid), .ready(ready), .retire(retire),
        .writeEnable(writeEnable), .writeAddress(writeAddress), .writeData(writeData),
        .pc(pc)
    );

    task automatic reportFailure(input string text);
        $display("%s", text);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        assert (actual === expected) else
            reportFailure($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
    endtask

    function automatic logic [memIndexWidth-1:0] memIndex(input logic [`XLEN-1:0] address);
        return memIndexWidth'((address / 8) % `MEM_DEPTH); // Doubleword slot, wrapping.
    endfunction

    function automatic logic isSupportedOpcode(input logic [6:0] op);
        return op == OP_REG || op == OP_IMM || op == OP_LOAD || op == OP_STORE ||
               op == OP_BRANCH || op == OP_JAL || op == OP_JALR || op == OP_LUI;
    endfunction

    // Builds one instruction word together with the fields the model needs.
    task automatic generateInstruction(input int index, output logic [31:0] word,
                                       output instrKind_t kind, output logic [4:0] rd,
                                       output logic [4:0] rs1, output logic [4:0] rs2,
                                       output logic [`XLEN-1:0] imm);
        int          choice;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [19:0] imm20;
        logic [20:0] imm21;
        logic [6:0]  badOpcode;
        rd = 5'($urandom_range(0, 7));
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        imm12 = 12'($urandom);
        imm13 = {12'($urandom), 1'b0};
        imm20 = 20'($urandom);
        imm21 = {20'($urandom), 1'b0};
        if (index < setupLength) begin
            choice = ($urandom_range(0, 4) == 0) ? 35 : 20; // Mostly ADDI, some LUI.
            imm12 = 12'($urandom_range(0, 255));
        end else begin
            choice = $urandom_range(0, 99);
        end
        imm = '0;
        if (choice < 5) begin
            kind = KIND_ILLEGAL;
            do badOpcode = 7'($urandom); while (isSupportedOpcode(badOpcode));
            word = {25'($urandom), badOpcode};
        end else if (choice < 12) begin
            kind = KIND_ADD;
            word = {7'b0000000, rs2, rs1, 3'b000, rd, OP_REG};
        end else if (choice < 18) begin
            kind = KIND_SUB;
            word = {7'b0100000, rs2, rs1, 3'b000, rd, OP_REG};
        end else if (choice < 33) begin
            kind = KIND_ADDI;
            word = {imm12, rs1, 3'b000, rd, OP_IMM};
            imm = {{(`XLEN - 12){imm12[11]}}, imm12};
        end else if (choice < 40) begin
            kind = KIND_LUI;
            word = {imm20, rd, OP_LUI};
            imm = {{(`XLEN - 32){imm20[19]}}, imm20, 12'h000};
        end else if (choice < 53) begin
            kind = KIND_SD;
            word = {imm12[11:5], rs2, rs1, 3'b011, imm12[4:0], OP_STORE};
            imm = {{(`XLEN - 12){imm12[11]}}, imm12};
            haveStore = 1'b1;
            lastStoreBase = rs1;
            lastStoreOffset = imm12;
        end else if (choice < 66) begin
            kind = KIND_LD;
            if (haveStore && $urandom_range(0, 1) == 1) begin
                rs1 = lastStoreBase; // Often read back the most recent store.
                imm12 = lastStoreOffset;
            end
            word = {imm12, rs1, 3'b011, rd, OP_LOAD};
            imm = {{(`XLEN - 12){imm12[11]}}, imm12};
        end else if (choice < 82) begin
            kind = (choice < 74) ? KIND_BEQ : KIND_BNE;
            word = {imm13[12], imm13[10:5], rs2, rs1, (choice < 74) ? 3'b000 : 3'b001,
                    imm13[4:1], imm13[11], OP_BRANCH};
            imm = {{(`XLEN - 13){imm13[12]}}, imm13};
        end else if (choice < 91) begin
            kind = KIND_JAL;
            word = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, OP_JAL};
            imm = {{(`XLEN - 21){imm21[20]}}, imm21};
        end else begin
            kind = KIND_JALR;
            word = {imm12, rs1, 3'b000, rd, OP_JALR};
            imm = {{(`XLEN - 12){imm12[11]}}, imm12};
        end
    endtask

    // Executes one instruction on the model and returns what retire must show.
    task automatic predictRetire(input instrKind_t kind, input logic [4:0] rd,
                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                 input logic [`XLEN-1:0] imm, output logic expWe,
                                 output logic [`XLEN-1:0] expData, output int latency);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] nextPc;
        logic             writes;
        a = modelRegs[rs1];
        b = modelRegs[rs2];
        nextPc = modelPc + 4;
        writes = 1'b1;
        expData = '0;
        latency = 2;
        case (kind)
            KIND_ADD:  expData = a + b;
            KIND_SUB:  expData = a - b;
            KIND_ADDI: expData = a + imm;
            KIND_LUI:  expData = imm;
            KIND_LD: begin
                expData = modelMem[memIndex(a + imm)];
                latency = 3;
            end
            KIND_SD: begin
                modelMem[memIndex(a + imm)] = b;
                writes = 1'b0;
                latency = 3;
            end
            KIND_BEQ: begin
                writes = 1'b0;
                if (a == b) nextPc = modelPc + imm;
            end
            KIND_BNE: begin
                writes = 1'b0;
                if (a != b) nextPc = modelPc + imm;
            end
            KIND_JAL: begin
                expData = modelPc + 4;
                nextPc = modelPc + imm;
            end
            KIND_JALR: begin
                expData = modelPc + 4;
                nextPc = (a + imm) & ~64'd1;
            end
            default: writes = 1'b0; // Illegal opcodes only advance the PC.
        endcase
        expWe = writes && (rd != 0);
        if (expWe) modelRegs[rd] = expData;
        modelPc = nextPc;
    endtask

    // Called on a falling edge; returns on the falling edge after the retire cycle.
    task automatic issueAndCheck(input logic [31:0] word, input logic [4:0] expAddr,
                                 input logic expWe, input logic [`XLEN-1:0] expData,
                                 input logic [`XLEN-1:0] expPc, input int latency);
        int edgesAfter;
        assert (ready) else reportFailure("The core was not ready to accept an instruction.");
        instruction = word;
        instructionValid = 1'b1;
        @(negedge clock);
        edgesAfter = 0;
        while (!retire) begin
            assert (!ready) else reportFailure("Ready was high while an instruction was busy.");
            assert (edgesAfter < latency) else
                reportFailure($sformatf("Retire did not come %0d edges after accept.", latency));
            instruction = $urandom; // The core must ignore these while busy.
            instructionValid = 1'($urandom_range(0, 1));
            @(negedge clock);
            edgesAfter++;
        end
        assert (edgesAfter == latency) else
            reportFailure($sformatf("Retire came %0d edges after accept.", edgesAfter));
        assert (!ready) else reportFailure("Ready was high in the retire cycle.");
        checkValue("writeEnable", 64'(writeEnable), 64'(expWe));
        if (expWe) begin
            checkValue("writeAddress", 64'(writeAddress), 64'(expAddr));
            checkValue("writeData", writeData, expData);
        end
        checkValue("pc", pc, expPc);
        @(negedge clock);
        assert (!retire) else reportFailure("Retire stayed high for more than one cycle.");
        assert (ready) else reportFailure("Ready did not return in the cycle after retire.");
        instructionValid = 1'b0;
    endtask

    initial begin
        #((programLength * 6 + resetCycles) * clockPeriod);
        reportFailure("The watchdog expired because the core stopped retiring instructions.");
    end

    initial begin
        logic [31:0]      word;
        instrKind_t       kind;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [`XLEN-1:0] imm;
        logic             expWe;
        logic [`XLEN-1:0] expData;
        int               latency;
        void'($urandom(32'hdcc2_15d4));
        reset = 1'b1;
        instruction = '0;
        instructionValid = 1'b0;
        modelRegs = '{default: '0};
        modelMem = '{default: '0};
        modelPc = '0;
        haveStore = 1'b0;
        lastStoreBase = '0;
        lastStoreOffset = '0;
        repeat (resetCycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        assert (ready) else reportFailure("Ready was low after reset.");
        assert (!retire) else reportFailure("Retire was high after reset.");
        checkValue("writeEnable", 64'(writeEnable), 64'd0);
        checkValue("pc", pc, '0);
        for (int n = 0; n < programLength; n++) begin
            generateInstruction(n, word, kind, rd, rs1, rs2, imm);
            predictRetire(kind, rd, rs1, rs2, imm, expWe, expData, latency);
            issueAndCheck(word, rd, expWe, expData, modelPc, latency);
            if ($urandom_range(0, 3) == 0) @(negedge clock); // Occasional idle cycle.
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/corePkg.sv
src/immediateGenerator.sv
src/controlUnit.sv
src/registerFile.sv
src/arithmeticUnit.sv
src/dataMemory.sv
src/rvCore.sv
testbench/clockGenerator.sv
testbench/rvCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rvCoreTb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MESSAGE ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)
